// File: vlog.f
source/ethLinePkg.sv
source/ethHostPkg.sv
source/crc32Byte.sv
source/ethRxDeframer.sv
source/ethTxFramer.sv
source/ethRtStatus.sv
source/ethRtInterface.sv
verif/ethRtTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the port adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module ethRtTb -o ethRtSim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/ethRtSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// File: verif/ethRtTb.sv
// ----------------------------------------------------------
// Testbench for the Ethernet port adapter: switch model,
// host model and reference CRC, driven from a case table
// ----------------------------------------------------------
module ethRtTb;
    import ethHostPkg::*;

    localparam int minFrameBytes = 64;
    localparam int numCases      = 6;

    typedef struct {
        string name;
        int    nBytes;      // Payload bytes, both directions
        int    mode;        // 0 response, 1 forward, 2 both pending
        bit    busy;        // recvBusy level
        bit    expErr;      // internalError after the case
        int    jump;        // Timestamp jump during the frame
    } caseT;

    logic       TxClk;
    logic       resetActive;
    logic       clearErrors;
    logic       PortReady, DataReady, RxValid, TxEn, TxErr;
    logic [7:0] RxD, TxD;
    logic       sendReq, responseRequired, isForward;
    logic       recvRequest, recvBusy, recvReady, sendRequest, sendBusy, sendReady;
    byteCountT  responseByteCount;
    hostWordT   recvWord;
    hostWordT   sendWord = 16'h0000;
    timeT       timestamp = 32'd0;
    shortTimeT  timeReceive, timeNow;
    regAddrT    regAddr;
    regDataT    regData;
    logic       internalError;

    caseT       cases [numCases];
    logic [7:0] payload [128];
    hostWordT   rxGot [$];          // Words seen on recvReady
    int         reqCycles = 0;      // Cycles with recvRequest high
    logic [1:0] prHist = 2'b00;     // PortReady history, newest in bit 0
    logic [31:0] tsJump;
    longint     cycleCnt = 0;
    int         wordIdx = 0;
    int         errors = 0;
    int         checks = 0;
    integer     seed;

    ethRtInterface #(
        .minFrameBytes (minFrameBytes),
        .hasDebugData  (1'b1)
    ) u_dut (
        .TxClk (TxClk), .resetActive (resetActive), .clearErrors (clearErrors),
        .PortReady (PortReady), .DataReady (DataReady),
        .RxValid (RxValid), .RxD (RxD),
        .TxEn (TxEn), .TxD (TxD), .TxErr (TxErr),
        .sendReq (sendReq), .responseRequired (responseRequired),
        .responseByteCount (responseByteCount), .isForward (isForward),
        .recvRequest (recvRequest), .recvBusy (recvBusy),
        .recvReady (recvReady), .recvWord (recvWord),
        .sendRequest (sendRequest), .sendBusy (sendBusy),
        .sendReady (sendReady), .sendWord (sendWord),
        .timestamp (timestamp), .timeReceive (timeReceive), .timeNow (timeNow),
        .regAddr (regAddr), .regData (regData), .internalError (internalError)
    );

    initial begin
        TxClk = 1'b0;
        forever #2 TxClk = ~TxClk;
    end

    // ----------------------------------------------------------
    // Free-running time, host word source, monitors
    // ----------------------------------------------------------
    always @(posedge TxClk) begin
        timestamp <= timestamp + 32'd1 + tsJump;    // Jump lasts one edge
        cycleCnt  <= cycleCnt + 1;
    end

    // Host restarts at word 0 while sendRequest is up, then steps on sendReady
    always @(posedge TxClk) begin
        if (sendRequest) begin
            wordIdx  <= 0;
            sendWord <= {payload[1], payload[0]};
        end else if (sendReady) begin
            wordIdx  <= wordIdx + 1;
            sendWord <= {payload[2 * wordIdx + 3], payload[2 * wordIdx + 2]};  // Low byte first
        end
    end

    always @(negedge TxClk) begin
        prHist <= {prHist[0], PortReady};
        if (recvReady === 1'b1) rxGot.push_back(recvWord);
        if (recvRequest === 1'b1) reqCycles++;
    end

    task automatic checkEqual(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", what, exp, act);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Checks: %0d, errors: %0d, timeouts: 1", checks, errors);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // Ethernet FCS, reflected form, bytes go out LSB first
    function automatic logic [31:0] refCrc(input logic [7:0] data [$]);
        logic [31:0] crc;
        crc = 32'hFFFFFFFF;
        foreach (data[i]) begin
            crc = crc ^ {24'd0, data[i]};
            for (int k = 0; k < 8; k++) begin
                crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    // Switch model: a byte only goes out when PortReady was high two cycles back
    task automatic sendRxFrame(input int n, input int jump,
                               output longint firstCyc, output longint lastCyc);
        int i;
        int tmo;
        i   = 0;
        tmo = 0;
        while (i < n + 8) begin
            @(posedge TxClk);
            if (prHist[1]) begin
                RxValid <= 1'b1;
                RxD     <= (i < 7) ? 8'h55 : ((i == 7) ? 8'hD5 : payload[i - 8]);
                tsJump  <= (i == 8) ? 32'(jump) : 32'd0;   // Jump at the first payload byte
                if (i == 0) firstCyc = cycleCnt;
                lastCyc = cycleCnt;
                i++;
                tmo = 0;
            end else begin
                RxValid <= 1'b0;
                tsJump  <= 32'd0;
                tmo++;
                if (tmo > 100) timeoutFail("PortReady before a receive byte");
            end
        end
        @(posedge TxClk);
        RxValid <= 1'b0;
        tsJump  <= 32'd0;
    endtask

    // Capture one TxEn burst and compare with the expected frame
    task automatic collectTxFrame(input string name, input int n, input bit expFwd);
        logic [7:0] got [$];
        logic [7:0] body [$];
        logic [7:0] expq [$];
        logic [31:0] fcs;
        int tmo;
        logic fwdSeen;
        tmo = 0;
        @(negedge TxClk);
        while (TxEn !== 1'b1) begin
            tmo++;
            if (tmo > 400) timeoutFail({name, " TxEn rise"});
            @(negedge TxClk);
        end
        fwdSeen = isForward;
        while (TxEn === 1'b1) begin
            got.push_back(TxD);
            if (got.size() > 400) timeoutFail({name, " TxEn fall"});
            @(negedge TxClk);
        end
        for (int i = 0; i < n || i < minFrameBytes - 4; i++) begin
            body.push_back(payload[i]);                 // Zero beyond n doubles as padding
        end
        fcs = refCrc(body);
        repeat (7) expq.push_back(8'h55);
        expq.push_back(8'hD5);
        foreach (body[i]) expq.push_back(body[i]);
        for (int k = 0; k < 4; k++) expq.push_back(fcs[8 * k +: 8]);
        checkEqual({name, " TxEn length"}, 32'(expq.size()), 32'(got.size()));
        checkEqual({name, " isForward"}, {31'd0, expFwd}, {31'd0, fwdSeen});
        for (int i = 0; i < expq.size() && i < got.size(); i++) begin
            checkEqual($sformatf("%s TxD[%0d]", name, i), {24'd0, expq[i]}, {24'd0, got[i]});
        end
    endtask

    task automatic runCase(input caseT c);
        longint firstCyc;
        longint lastCyc;
        longint expTime;
        int tmo;
        for (int i = 0; i < 128; i++) begin
            payload[i] = (i < c.nBytes) ? 8'($random(seed)) : 8'h00;
        end
        @(posedge TxClk);
        recvBusy          <= c.busy;
        responseRequired  <= (c.mode != 1);
        responseByteCount <= 16'(c.nBytes);
        sendBusy          <= (c.mode == 2);
        rxGot.delete();
        reqCycles = 0;
        sendRxFrame(c.nBytes, c.jump, firstCyc, lastCyc);

        if (c.mode == 1) begin
            @(posedge TxClk);
            sendReq <= 1'b1;
            @(posedge TxClk);
            sendReq <= 1'b0;
            collectTxFrame(c.name, c.nBytes, 1'b1);
        end else if (c.mode == 2) begin
            tmo = 0;
            @(negedge TxClk);
            while (PortReady !== 1'b0) begin
                tmo++;
                if (tmo > 50) timeoutFail("PortReady to drop in rxWaitSend");
                @(negedge TxClk);
            end
            repeat (16) begin
                @(negedge TxClk);
                checkEqual({c.name, " PortReady held"}, 32'd0, {31'd0, PortReady});
            end
            @(posedge TxClk);
            sendBusy <= 1'b0;
            // Forward request reaches the framer together with sendResponse
            @(posedge TxClk);
            sendReq  <= 1'b1;
            @(posedge TxClk);
            sendReq  <= 1'b0;
            collectTxFrame({c.name, " fwd"}, c.nBytes, 1'b1);
            collectTxFrame({c.name, " resp"}, c.nBytes, 1'b0);
        end else begin
            collectTxFrame(c.name, c.nBytes, 1'b0);
        end

        // Receive words, first byte high, odd tail zero padded
        checkEqual({c.name, " word count"}, c.busy ? 32'((c.nBytes + 1) / 2) : 32'd0,
                   32'(rxGot.size()));
        for (int k = 0; k < rxGot.size() && c.busy; k++) begin
            checkEqual($sformatf("%s recvWord[%0d]", c.name, k),
                       {16'd0, payload[2 * k], payload[2 * k + 1]}, {16'd0, rxGot[k]});
        end

        // Seven preamble bytes and the SFD, back to back
        checkEqual({c.name, " recvRequest cycles"}, 32'd8, 32'(reqCycles));

        if (c.mode != 1) begin
            expTime = lastCyc - firstCyc + 3 + longint'(c.jump);
            if (expTime > 65535) expTime = 65535;       // Saturated
            checkEqual({c.name, " timeReceive"}, 32'(expTime), {16'd0, timeReceive});
        end

        // Start time is taken two edges after the first preamble byte goes out
        @(negedge TxClk);
        expTime = cycleCnt - firstCyc - 2 + longint'(c.jump);
        if (expTime > 65535) expTime = 65535;
        checkEqual({c.name, " timeNow"}, 32'(expTime), {16'd0, timeNow});

        checkEqual({c.name, " internalError"}, {31'd0, c.expErr}, {31'd0, internalError});
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        resetActive       = 1'b1;
        clearErrors       = 1'b0;
        RxValid           = 1'b0;
        RxD               = 8'h00;
        sendReq           = 1'b0;
        responseRequired  = 1'b0;
        responseByteCount = 16'd0;
        recvBusy          = 1'b0;
        sendBusy          = 1'b0;
        regAddr           = 16'h0000;
        tsJump            = 32'd0;
        seed              = 32'had41;

        cases[0] = '{"evenResp", 20, 0, 1'b1, 1'b0, 0};
        cases[1] = '{"oddResp",  7,  0, 1'b1, 1'b0, 100};
        cases[2] = '{"fwdLong",  70, 1, 1'b1, 1'b0, 0};
        cases[3] = '{"bothPend", 11, 2, 1'b1, 1'b0, 0};
        cases[4] = '{"notReady", 9,  0, 1'b0, 1'b1, 0};
        cases[5] = '{"bigJump",  6,  0, 1'b1, 1'b1, 70000};    // Error still sticky

        repeat (8) @(posedge TxClk);
        resetActive <= 1'b0;
        @(negedge TxClk);
        checkEqual("reset TxEn", 32'd0, {31'd0, TxEn});
        checkEqual("reset isForward", 32'd0, {31'd0, isForward});
        checkEqual("reset PortReady", 32'd0, {31'd0, PortReady});
        checkEqual("reset DataReady", 32'd0, {31'd0, DataReady});
        checkEqual("TxErr", 32'd0, {31'd0, TxErr});
        @(negedge TxClk);
        checkEqual("PortReady after reset", 32'd1, {31'd0, PortReady});

        for (int i = 0; i < numCases; i++) begin
            runCase(cases[i]);
        end

        // Sticky error clears only on clearErrors
        @(posedge TxClk);
        clearErrors <= 1'b1;
        @(posedge TxClk);
        clearErrors <= 1'b0;
        @(negedge TxClk);
        checkEqual("clearErrors", 32'd0, {31'd0, internalError});

        // Debug window: signature at page A, nothing elsewhere
        @(posedge TxClk);
        regAddr <= 16'h00A0;
        @(negedge TxClk);
        checkEqual("debug signature", 32'h33474244, regData);   // "3GBD"
        @(posedge TxClk);
        regAddr <= 16'h0050;
        @(negedge TxClk);
        checkEqual("other page", 32'd0, regData);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: source/ethRtInterface.sv
// ----------------------------------------------------------
// Real-time Ethernet port adapter between the GMII switch
// port and the word-wide host packet engine
// ----------------------------------------------------------
module ethRtInterface #(
    parameter int minFrameBytes = 64,
    parameter bit hasDebugData  = 1'b1
) (
    input  logic                  TxClk,
    input  logic                  resetActive,
    input  logic                  clearErrors,
    // Switch side, GMII plus flow control
    output logic                  PortReady,
    output logic                  DataReady,
    input  logic                  RxValid,
    input  logic [7:0]            RxD,
    output logic                  TxEn,
    output logic [7:0]            TxD,
    output logic                  TxErr,
    // Host side
    input  logic                  sendReq,
    input  logic                  responseRequired,
    input  ethHostPkg::byteCountT responseByteCount,
    output logic                  isForward,
    output logic                  recvRequest,
    input  logic                  recvBusy,
    output logic                  recvReady,
    output ethHostPkg::hostWordT  recvWord,
    output logic                  sendRequest,
    input  logic                  sendBusy,
    output logic                  sendReady,
    input  ethHostPkg::hostWordT  sendWord,
    // Timing and debug
    input  ethHostPkg::timeT      timestamp,
    output ethHostPkg::shortTimeT timeReceive,
    output ethHostPkg::shortTimeT timeNow,
    input  ethHostPkg::regAddrT   regAddr,
    output ethHostPkg::regDataT   regData,
    output logic                  internalError
);
    import ethLinePkg::*;

    logic    sendResponse;      // Deframer to framer
    logic    rxStart;
    logic    rxEnd;
    logic    rxNotReady;
    logic    txBadState;
    rxStateT rxState;
    txStateT txState;

    assign TxErr = 1'b0;        // Never signal a line error

    ethRxDeframer uRx (
        .TxClk            (TxClk),
        .resetActive      (resetActive),
        .RxValid          (RxValid),
        .RxD              (RxD),
        .recvBusy         (recvBusy),
        .sendBusy         (sendBusy),
        .responseRequired (responseRequired),
        .PortReady        (PortReady),
        .recvRequest      (recvRequest),
        .recvReady        (recvReady),
        .recvWord         (recvWord),
        .sendResponse     (sendResponse),
        .rxStart          (rxStart),
        .rxEnd            (rxEnd),
        .rxNotReady       (rxNotReady),
        .rxState          (rxState)
    );

    ethTxFramer #(
        .minFrameBytes (minFrameBytes)
    ) uTx (
        .TxClk             (TxClk),
        .resetActive       (resetActive),
        .sendReq           (sendReq),
        .sendResponse      (sendResponse),
        .responseByteCount (responseByteCount),
        .sendWord          (sendWord),
        .isForward         (isForward),
        .sendRequest       (sendRequest),
        .sendReady         (sendReady),
        .TxEn              (TxEn),
        .TxD               (TxD),
        .DataReady         (DataReady),
        .txState           (txState),
        .txBadState        (txBadState)
    );

    ethRtStatus #(
        .hasDebugData (hasDebugData)
    ) uStatus (
        .TxClk         (TxClk),
        .resetActive   (resetActive),
        .clearErrors   (clearErrors),
        .timestamp     (timestamp),
        .rxStart       (rxStart),
        .rxEnd         (rxEnd),
        .rxNotReady    (rxNotReady),
        .txBadState    (txBadState),
        .rxState       (rxState),
        .txState       (txState),
        .regAddr       (regAddr),
        .timeNow       (timeNow),
        .timeReceive   (timeReceive),
        .regData       (regData),
        .internalError (internalError)
    );

endmodule

// File: source/ethRtStatus.sv
// ----------------------------------------------------------
// Receive timing, sticky error flags and debug readback
// ----------------------------------------------------------
module ethRtStatus #(
    parameter bit hasDebugData = 1'b1
) (
    input  logic                  TxClk,
    input  logic                  resetActive,
    input  logic                  clearErrors,
    input  ethHostPkg::timeT      timestamp,
    input  logic                  rxStart,          // Frame request seen
    input  logic                  rxEnd,            // Frame done, response due
    input  logic                  rxNotReady,
    input  logic                  txBadState,
    input  ethLinePkg::rxStateT   rxState,
    input  ethLinePkg::txStateT   txState,
    input  ethHostPkg::regAddrT   regAddr,
    output ethHostPkg::shortTimeT timeNow,
    output ethHostPkg::shortTimeT timeReceive,
    output ethHostPkg::regDataT   regData,
    output logic                  internalError
);
    import ethHostPkg::*;

    timeT    startTime;
    timeT    elapsed;
    logic    notReadyErr;
    logic    badStateErr;
    regDataT debugWord;

    assign elapsed = timestamp - startTime;
    assign timeNow = (elapsed[31:16] != 16'h0) ? 16'hFFFF : elapsed[15:0];  // Saturate

    always_ff @(posedge TxClk) begin
        if (rxStart) startTime <= timestamp;
        if (rxEnd) timeReceive <= timeNow;
    end

    // Sticky until cleared by the host
    always_ff @(posedge TxClk) begin
        if (resetActive | clearErrors) begin
            notReadyErr <= 1'b0;
            badStateErr <= 1'b0;
        end else begin
            if (rxNotReady) notReadyErr <= 1'b1;
            if (txBadState) badStateErr <= 1'b1;
        end
    end

    assign internalError = notReadyErr | badStateErr;

    // ----------------------------------------------------------
    // Debug window, four words
    // ----------------------------------------------------------
    always_comb begin
        case (regAddr[1:0])
            2'd0:    debugWord = debugSignature;
            2'd1:    debugWord = {rxState, 3'd0, txState, 22'd0, notReadyErr, badStateErr};
            2'd2:    debugWord = {timeReceive, timeNow};
            default: debugWord = startTime;
        endcase
    end

    assign regData = (hasDebugData && regAddr[7:4] == debugPage) ? debugWord : '0;

endmodule

// File: source/ethTxFramer.sv
// ----------------------------------------------------------
// GMII transmit side: preamble, host word unpacking, zero
// padding and the FCS appended to every frame
// ----------------------------------------------------------
module ethTxFramer #(
    parameter int minFrameBytes = 64
) (
    input  logic                  TxClk,
    input  logic                  resetActive,
    input  logic                  sendReq,              // Forwarding path, wins over response
    input  logic                  sendResponse,
    input  ethHostPkg::byteCountT responseByteCount,
    input  ethHostPkg::hostWordT  sendWord,             // Current host word
    output logic                  isForward,
    output logic                  sendRequest,
    output logic                  sendReady,            // Host advances on this edge
    output logic                  TxEn,
    output logic [7:0]            TxD,
    output logic                  DataReady,
    output ethLinePkg::txStateT   txState,
    output logic                  txBadState
);
    import ethLinePkg::*;
    import ethHostPkg::*;

    localparam byteCountT padLimit = byteCountT'(minFrameBytes - 4);   // Frame size less FCS

    byteCountT   txCount;       // Payload plus pad bytes sent
    logic [2:0]  stepCnt;       // Preamble and FCS byte counter
    logic [7:0]  highByte;      // Upper half of the word in flight
    logic        pendResponse;  // Response queued behind a forward frame
    logic [31:0] crcReg;
    logic [31:0] crcNext;
    logic [7:0]  curByte;
    logic [7:0]  crcData;
    logic        lastPayload;

    function automatic logic [7:0] bitRev(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7 - i];
        end
        return r;
    endfunction

    assign curByte     = txCount[0] ? highByte : sendWord[7:0];     // Low byte first
    assign crcData     = (txState == txSend) ? bitRev(curByte) : 8'h00;
    assign lastPayload = (txCount == responseByteCount - 16'd1);

    crc32Byte uCrc (
        .data   (crcData),
        .crcIn  (crcReg),
        .crcOut (crcNext)
    );

    always_ff @(posedge TxClk) begin
        if (resetActive) begin
            txState      <= txIdle;
            TxEn         <= 1'b0;
            DataReady    <= 1'b0;
            sendRequest  <= 1'b0;
            sendReady    <= 1'b0;
            isForward    <= 1'b0;
            pendResponse <= 1'b0;
            txBadState   <= 1'b0;
        end else begin
            txBadState <= 1'b0;
            if (sendResponse) pendResponse <= 1'b1;

            case (txState)
                txIdle: begin
                    TxEn      <= 1'b0;
                    DataReady <= 1'b1;
                    sendReady <= 1'b0;
                    txCount   <= '0;
                    stepCnt   <= '0;
                    if (sendReq) begin
                        isForward   <= 1'b1;
                        sendRequest <= 1'b1;
                        txState     <= txPreamble;
                    end else if (pendResponse | sendResponse) begin
                        isForward    <= 1'b0;
                        pendResponse <= 1'b0;
                        sendRequest  <= 1'b1;
                        txState      <= txPreamble;
                    end
                end

                txPreamble: begin
                    TxEn <= 1'b1;
                    if (stepCnt == preambleLen) begin
                        TxD         <= sfdByte;
                        sendRequest <= 1'b0;        // Host is busy by now
                        sendReady   <= 1'b1;
                        crcReg      <= crcInit;
                        txState     <= txSend;
                    end else begin
                        TxD     <= preambleByte;
                        stepCnt <= stepCnt + 3'd1;
                    end
                end

                txSend: begin
                    TxD <= curByte;
                    if (!txCount[0]) highByte <= sendWord[15:8];
                    crcReg    <= crcNext;
                    sendReady <= txCount[0] & ~lastPayload;     // Once per word
                    txCount   <= txCount + 16'd1;
                    if (lastPayload) begin
                        stepCnt <= '0;
                        txState <= (txCount + 16'd1 >= padLimit) ? txCrc : txPadding;
                    end
                end

                txPadding: begin
                    TxD     <= 8'h00;
                    crcReg  <= crcNext;             // Pad bytes count in the FCS
                    txCount <= txCount + 16'd1;
                    if (txCount == padLimit - 16'd1) txState <= txCrc;
                end

                // ----------------------------------------------------------
                // FCS, complemented and reflected, top byte first
                // ----------------------------------------------------------
                txCrc: begin
                    TxD    <= ~bitRev(crcReg[31:24]);
                    crcReg <= {crcReg[23:0], crcReg[31:24]};
                    if (stepCnt == crcBytes - 3'd1) begin
                        txState <= txIdle;
                    end else begin
                        stepCnt <= stepCnt + 3'd1;
                    end
                end

                default: begin
                    txBadState <= 1'b1;
                    txState    <= txIdle;
                end
            endcase
        end
    end

endmodule

// File: source/ethRxDeframer.sv
// ----------------------------------------------------------
// GMII receive side: strips the preamble, packs byte pairs
// into host words and asks for a response at end of frame
// ----------------------------------------------------------
module ethRxDeframer (
    input  logic                 TxClk,
    input  logic                 resetActive,
    input  logic                 RxValid,           // Byte from switch FIFO
    input  logic [7:0]           RxD,
    input  logic                 recvBusy,          // Host is taking this frame
    input  logic                 sendBusy,          // Host send still pending
    input  logic                 responseRequired,
    output logic                 PortReady,         // Switch may deliver 2 cycles later
    output logic                 recvRequest,
    output logic                 recvReady,         // One-cycle word strobe
    output ethHostPkg::hostWordT recvWord,
    output logic                 sendResponse,      // Pulse to the framer
    output logic                 rxStart,
    output logic                 rxEnd,
    output logic                 rxNotReady,
    output ethLinePkg::rxStateT  rxState
);
    import ethLinePkg::*;
    import ethHostPkg::*;

    byteCountT  byteCount;      // Payload bytes since the SFD
    logic [1:0] gapCnt;         // Idle cycles left before end of frame

    always_ff @(posedge TxClk) begin
        if (resetActive) begin
            rxState      <= rxIdle;
            PortReady    <= 1'b0;
            recvRequest  <= 1'b0;
            recvReady    <= 1'b0;
            sendResponse <= 1'b0;
            rxStart      <= 1'b0;
            rxEnd        <= 1'b0;
            rxNotReady   <= 1'b0;
        end else begin
            // Strobes default low
            recvReady    <= 1'b0;
            sendResponse <= 1'b0;
            rxStart      <= 1'b0;
            rxEnd        <= 1'b0;
            rxNotReady   <= 1'b0;

            case (rxState)
                rxIdle: begin
                    PortReady <= 1'b1;
                    if (RxValid) begin
                        recvRequest <= 1'b1;
                        rxStart     <= ~recvRequest;    // Rising edge of recvRequest
                        // Preamble content is not checked
                        if (RxD == sfdByte) begin
                            byteCount  <= '0;
                            gapCnt     <= rxEndGap - 2'd1;
                            rxNotReady <= ~recvBusy;    // Host missed the request
                            rxState    <= rxFrame;
                        end
                    end
                end

                rxFrame: begin
                    if (RxValid) begin
                        recvRequest <= 1'b0;
                        gapCnt      <= rxEndGap - 2'd1;
                        byteCount   <= byteCount + 16'd1;
                        if (!byteCount[0]) begin
                            recvWord[15:8] <= RxD;      // First byte of the pair
                        end else begin
                            recvWord[7:0] <= RxD;
                            recvReady     <= recvBusy;
                        end
                    end else if (gapCnt != 2'd0) begin
                        gapCnt <= gapCnt - 2'd1;
                    end else begin
                        // ------------------------------------------------
                        // End of frame
                        // ------------------------------------------------
                        recvRequest <= 1'b0;
                        if (byteCount[0]) begin
                            recvWord[7:0] <= 8'h00;     // Odd length, pad low half
                            recvReady     <= recvBusy;
                        end
                        if (responseRequired) begin
                            rxEnd <= 1'b1;
                            if (sendBusy) begin
                                PortReady <= 1'b0;      // No new frames while we wait
                                rxState   <= rxWaitSend;
                            end else begin
                                sendResponse <= 1'b1;
                                rxState      <= rxIdle;
                            end
                        end else begin
                            rxState <= rxIdle;
                        end
                    end
                end

                rxWaitSend: begin
                    if (!sendBusy) begin
                        sendResponse <= 1'b1;
                        rxState      <= rxIdle;
                    end
                end

                default: rxState <= rxIdle;
            endcase
        end
    end

endmodule

// File: source/crc32Byte.sv
// ----------------------------------------------------------
// CRC-32 remainder update for one byte, MSB of data first
// ----------------------------------------------------------
module crc32Byte (
    input  logic [7:0]  data,       // Byte, already bit-reversed by the caller
    input  logic [31:0] crcIn,      // Running remainder
    output logic [31:0] crcOut      // Remainder after eight bit steps
);
    import ethLinePkg::*;

    logic [31:0] stepCrc;           // Remainder between bit steps

    // Plain LFSR division, unrolled by the loop
    always_comb begin
        stepCrc = crcIn;
        for (int i = 7; i >= 0; i--) begin
            if (stepCrc[31] ^ data[i]) begin
                stepCrc = {stepCrc[30:0], 1'b0} ^ crcPoly;
            end else begin
                stepCrc = {stepCrc[30:0], 1'b0};
            end
        end
        crcOut = stepCrc;
    end

endmodule

// File: source/ethHostPkg.sv
// ----------------------------------------------------------
// Host-side types for the packet engine interface
// Word and count widths, debug register window
// ----------------------------------------------------------
package ethHostPkg;

    typedef logic [15:0] hostWordT;     // One host word, two line bytes
    typedef logic [15:0] byteCountT;    // Frame byte count
    typedef logic [31:0] timeT;         // Free-running timestamp
    typedef logic [15:0] shortTimeT;    // Saturated elapsed time
    typedef logic [15:0] regAddrT;
    typedef logic [31:0] regDataT;

    // ----------------------------------------------------------
    // Debug window
    // ----------------------------------------------------------
    localparam regDataT    debugSignature = "3GBD";  // DBG3, byte-swapped for the host
    localparam logic [3:0] debugPage      = 4'hA;    // Matched against address bits 7:4

endpackage

// File: source/ethLinePkg.sv
// ----------------------------------------------------------
// Line-side constants for the GMII port adapter
// Preamble bytes, CRC-32 setup and the receive/transmit FSMs
// ----------------------------------------------------------
package ethLinePkg;

    // Preamble and start-of-frame delimiter
    localparam logic [7:0] preambleByte = 8'h55;
    localparam logic [7:0] sfdByte      = 8'hD5;
    localparam logic [2:0] preambleLen  = 3'd7;    // Bytes of 0x55 before the SFD

    // ----------------------------------------------------------
    // CRC-32 (IEEE 802.3)
    // ----------------------------------------------------------
    localparam logic [31:0] crcPoly  = 32'h04C11DB7;  // Normal (MSB-first) form
    localparam logic [31:0] crcInit  = 32'hFFFFFFFF;
    localparam logic [2:0]  crcBytes = 3'd4;           // FCS length on the wire

    // Idle cycles on RxValid that close a frame
    localparam logic [1:0] rxEndGap = 2'd3;

    // ----------------------------------------------------------
    // State machines
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        rxIdle,                 // Hunting for the SFD
        rxFrame,                // Packing payload bytes
        rxWaitSend              // Response held off by a busy sender
    } rxStateT;

    typedef enum logic [2:0] {
        txIdle,
        txPreamble,             // 7 x 0x55 then 0xD5
        txSend,                 // Host payload
        txPadding,              // Zero fill up to the minimum size
        txCrc                   // Four FCS bytes
    } txStateT;

endpackage
